//--- fix_mul.sv
module fix_mul (
    input  logic               clk,
    input  logic               rst_n,
    input  poly_pkg::fix_req_t req,
    output poly_pkg::fix_rsp_t rsp
);
    import poly_pkg::*;

    logic                   prod_vld;
    prod_t                  prod_q;      // raw 64-bit product
    prod_t                  prod_shift;
    fix_t                   prod_sat;
    logic [MUL_LATENCY-1:0] vld_pipe;
    fix_t                   data_pipe [MUL_LATENCY];

    // ----------------------------------------------------------
    // first stage is the multiply itself
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        prod_q <= prod_t'(req.a) * prod_t'(req.b);
    end

    // back to Q16.16, floor on the shift
    assign prod_shift = prod_q >>> FRAC_BITS;

    always_comb begin
        if (prod_shift > prod_t'(FIX_MAX)) begin
            prod_sat = FIX_MAX;
        end else if (prod_shift < prod_t'(FIX_MIN)) begin
            prod_sat = FIX_MIN;
        end else begin
            prod_sat = fix_t'(prod_shift);
        end
    end

    // ----------------------------------------------------------
    // delay chain, several products may be in flight
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_vld <= 1'b0;
            vld_pipe <= '0;
        end else begin
            prod_vld    <= req.valid;
            vld_pipe[0] <= prod_vld;
            for (int i = 1; i < MUL_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= prod_sat;
        for (int i = 1; i < MUL_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign rsp = '{valid: vld_pipe[MUL_LATENCY-1], data: data_pipe[MUL_LATENCY-1]};

endmodule

//--- pair_add.sv
module pair_add (
    input  logic               clk,
    input  logic               rst_n,
    input  poly_pkg::fix_rsp_t a_in,
    input  poly_pkg::fix_rsp_t b_in,
    output poly_pkg::fix_rsp_t sum
);
    import poly_pkg::*;

    logic                   have_a;
    logic                   have_b;
    fix_t                   hold_a;
    fix_t                   hold_b;
    logic                   launch;

    logic                   req_vld;
    fix_t                   req_a;
    fix_t                   req_b;

    wide_sum_t              raw_sum;
    fix_t                   sat_sum;
    logic [ADD_LATENCY-1:0] vld_pipe;
    fix_t                   data_pipe [ADD_LATENCY];

    // ----------------------------------------------------------
    // operand join, arrival order does not matter
    // ----------------------------------------------------------
    assign launch = have_a && have_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_a <= 1'b0;
            have_b <= 1'b0;
        end else begin
            // a fresh strobe wins over the clear on launch
            have_a <= a_in.valid || (have_a && !launch);
            have_b <= b_in.valid || (have_b && !launch);
        end
    end

    always_ff @(posedge clk) begin
        if (a_in.valid) begin
            hold_a <= a_in.data;
        end
        if (b_in.valid) begin
            hold_b <= b_in.data;
        end
    end

    // ----------------------------------------------------------
    // add request and saturating pipeline
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_vld  <= 1'b0;
            vld_pipe <= '0;
        end else begin
            req_vld     <= launch;
            vld_pipe[0] <= req_vld;
            for (int i = 1; i < ADD_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    assign raw_sum = wide_sum_t'(req_a) + wide_sum_t'(req_b);  // exact, 33 bits

    always_comb begin
        if (raw_sum > wide_sum_t'(FIX_MAX)) begin
            sat_sum = FIX_MAX;
        end else if (raw_sum < wide_sum_t'(FIX_MIN)) begin
            sat_sum = FIX_MIN;
        end else begin
            sat_sum = fix_t'(raw_sum);
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            req_a <= hold_a;
            req_b <= hold_b;
        end
        data_pipe[0] <= sat_sum;
        for (int i = 1; i < ADD_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign sum = '{valid: vld_pipe[ADD_LATENCY-1], data: data_pipe[ADD_LATENCY-1]};

endmodule

//--- poly_eval.f
poly_pkg.sv
fix_mul.sv
power_seq.sv
pair_add.sv
poly_eval.sv
tb_poly_eval.sv

//--- poly_eval.sv
module poly_eval (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  poly_pkg::fix_t x_in,
    output logic           busy,
    output poly_pkg::fix_t y,
    output logic           y_valid
);
    import poly_pkg::*;

    fix_rsp_t term1;  // x
    fix_rsp_t term2;  // x^2
    fix_rsp_t term3;  // x^3
    fix_rsp_t term4;  // x^4
    fix_rsp_t term5;  // x^5

    fix_rsp_t s12_sum;
    fix_rsp_t s34_sum;
    fix_rsp_t s1234_sum;
    fix_rsp_t all_sum;

    fix_t     y_q;  // last result

    // ----------------------------------------------------------
    // powers
    // ----------------------------------------------------------
    power_seq u_power (
        .clk  (clk),
        .rst_n(rst_n),
        .start(start),
        .x_in (x_in),
        .busy (busy),
        .term1(term1),
        .term2(term2),
        .term3(term3),
        .term4(term4),
        .term5(term5)
    );

    // ----------------------------------------------------------
    // adder tree ((x + x2) + (x3 + x4)) + x5
    // ----------------------------------------------------------
    pair_add u_s12 (
        .clk  (clk),
        .rst_n(rst_n),
        .a_in (term1),
        .b_in (term2),
        .sum  (s12_sum)
    );

    pair_add u_s34 (
        .clk  (clk),
        .rst_n(rst_n),
        .a_in (term3),
        .b_in (term4),
        .sum  (s34_sum)
    );

    pair_add u_s1234 (
        .clk  (clk),
        .rst_n(rst_n),
        .a_in (s12_sum),
        .b_in (s34_sum),
        .sum  (s1234_sum)
    );

    pair_add u_s_all (
        .clk  (clk),
        .rst_n(rst_n),
        .a_in (s1234_sum),
        .b_in (term5),
        .sum  (all_sum)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y_q <= '0;
        end else if (all_sum.valid) begin
            y_q <= all_sum.data;
        end
    end

    // new value shows in the strobe cycle, held afterwards
    assign y_valid = all_sum.valid;
    assign y       = all_sum.valid ? all_sum.data : y_q;

endmodule

//--- poly_pkg.sv
package poly_pkg;

    // ----------------------------------------------------------
    // number format
    // ----------------------------------------------------------
    localparam int FIX_W     = 32;
    localparam int FRAC_BITS = 16;  // Q16.16

    typedef logic signed [FIX_W-1:0]   fix_t;       // data path value
    typedef logic signed [2*FIX_W-1:0] prod_t;      // full product
    typedef logic signed [FIX_W:0]     wide_sum_t;  // sum with carry

    // clamp limits
    localparam fix_t FIX_MAX = {1'b0, {(FIX_W-1){1'b1}}};
    localparam fix_t FIX_MIN = {1'b1, {(FIX_W-1){1'b0}}};

    // ----------------------------------------------------------
    // pipeline depths
    // ----------------------------------------------------------
    localparam int MUL_LATENCY = 3;
    localparam int ADD_LATENCY = 2;

    // operation request into a multiplier
    typedef struct packed {
        logic valid;
        fix_t a;
        fix_t b;
    } fix_req_t;

    // one value plus its strobe
    typedef struct packed {
        logic valid;
        fix_t data;
    } fix_rsp_t;

    // power sequencer
    typedef enum logic [1:0] {
        IDLE,
        SQUARE,     // x*x in flight
        CUBE_QUAD,  // x2*x and x2*x2 in flight
        FIFTH       // x2*x3 in flight
    } power_state_e;

endpackage

//--- power_seq.sv
module power_seq (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  poly_pkg::fix_t     x_in,
    output logic               busy,
    output poly_pkg::fix_rsp_t term1,
    output poly_pkg::fix_rsp_t term2,
    output poly_pkg::fix_rsp_t term3,
    output poly_pkg::fix_rsp_t term4,
    output poly_pkg::fix_rsp_t term5
);
    import poly_pkg::*;

    power_state_e state;

    fix_req_t req_a;
    fix_req_t req_b;
    fix_rsp_t rsp_a;
    fix_rsp_t rsp_b;

    logic req_a_vld;
    logic req_b_vld;
    fix_t req_a_op1;
    fix_t req_a_op2;

    // stored powers of the current item
    fix_t x_q;
    fix_t x2_q;
    fix_t x3_q;
    fix_t x4_q;
    fix_t x5_q;

    logic t12_vld;
    logic t34_vld;
    logic t5_vld;

    logic accept;
    logic sq_done;
    logic cq_done;
    logic fifth_done;

    // ----------------------------------------------------------
    // sequencer events
    // ----------------------------------------------------------
    assign accept     = (state == IDLE) && start;
    assign sq_done    = (state == SQUARE) && rsp_a.valid;
    // equal latencies so both come back together
    assign cq_done    = (state == CUBE_QUAD) && rsp_a.valid && rsp_b.valid;
    assign fifth_done = (state == FIFTH) && rsp_a.valid;

    assign busy = (state != IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            req_a_vld <= 1'b0;
            req_b_vld <= 1'b0;
            t12_vld   <= 1'b0;
            t34_vld   <= 1'b0;
            t5_vld    <= 1'b0;
        end else begin
            req_a_vld <= accept || sq_done || cq_done;
            req_b_vld <= sq_done;  // x4 only
            t12_vld   <= sq_done;
            t34_vld   <= cq_done;
            t5_vld    <= fifth_done;
            case (state)
                IDLE:      if (accept)     state <= SQUARE;
                SQUARE:    if (sq_done)    state <= CUBE_QUAD;
                CUBE_QUAD: if (cq_done)    state <= FIFTH;
                FIFTH:     if (fifth_done) state <= IDLE;
                default:                   state <= IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------
    // operands and powers
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            x_q       <= x_in;
            req_a_op1 <= x_in;  // x*x
            req_a_op2 <= x_in;
        end
        if (sq_done) begin
            x2_q      <= rsp_a.data;
            req_a_op1 <= rsp_a.data;  // x2*x
            req_a_op2 <= x_q;
        end
        if (cq_done) begin
            x3_q      <= rsp_a.data;
            x4_q      <= rsp_b.data;
            req_a_op1 <= x2_q;  // x2*x3
            req_a_op2 <= rsp_a.data;
        end
        if (fifth_done) begin
            x5_q <= rsp_a.data;
        end
    end

    assign req_a = '{valid: req_a_vld, a: req_a_op1, b: req_a_op2};
    assign req_b = '{valid: req_b_vld, a: x2_q, b: x2_q};

    fix_mul u_mul_a (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req_a),
        .rsp  (rsp_a)
    );

    fix_mul u_mul_b (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req_b),
        .rsp  (rsp_b)
    );

    assign term1 = '{valid: t12_vld, data: x_q};
    assign term2 = '{valid: t12_vld, data: x2_q};
    assign term3 = '{valid: t34_vld, data: x3_q};
    assign term4 = '{valid: t34_vld, data: x4_q};
    assign term5 = '{valid: t5_vld,  data: x5_q};

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the polynomial evaluator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_poly_eval -f poly_eval.f -o tb_poly_eval

out=$(./obj_dir/tb_poly_eval)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

//--- tb_poly_eval.sv
module tb_poly_eval;
    import poly_pkg::*;

    // expected timing in edges after the accept edge
    localparam int T5_EDGE        = 3 * MUL_LATENCY + 6;
    localparam int T34_EDGE       = 2 * MUL_LATENCY + 4;
    localparam int ADD_STEP       = ADD_LATENCY + 2;
    localparam int TREE_EDGE      = T34_EDGE + 2 * ADD_STEP;
    localparam int Y_EDGE         = ((T5_EDGE > TREE_EDGE) ? T5_EDGE : TREE_EDGE) + ADD_STEP;
    localparam int BUSY_CYCLES    = T5_EDGE;
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk;
    logic rst_n;
    logic start;
    fix_t x_in;
    logic busy;
    fix_t y;
    logic y_valid;

    int value_errors  = 0;
    int timing_errors = 0;
    int cycle_count   = 0;

    poly_eval i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .x_in   (x_in),
        .busy   (busy),
        .y      (y),
        .y_valid(y_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // reference model in Q16.16 with clamping
    // ------------------------------------------------------------
    function automatic fix_t clamp_fix(input longint v);
        if (v > longint'(FIX_MAX)) begin
            return FIX_MAX;
        end else if (v < longint'(FIX_MIN)) begin
            return FIX_MIN;
        end
        return fix_t'(v);
    endfunction

    function automatic fix_t mul_q16(input fix_t a, input fix_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return clamp_fix(p >>> FRAC_BITS);  // floor
    endfunction

    function automatic fix_t add_q16(input fix_t a, input fix_t b);
        return clamp_fix(longint'(a) + longint'(b));
    endfunction

    function automatic fix_t poly_ref(input fix_t x);
        fix_t x2;
        fix_t x3;
        fix_t x4;
        fix_t x5;
        x2 = mul_q16(x, x);
        x3 = mul_q16(x2, x);
        x4 = mul_q16(x2, x2);
        x5 = mul_q16(x2, x3);
        return add_q16(add_q16(add_q16(x, x2), add_q16(x3, x4)), x5);
    endfunction

    // uniform over -4.0 .. +4.0
    function automatic fix_t rand_fix();
        int r;
        r = int'($urandom % 32'd524289) - 262144;
        return fix_t'(r);
    endfunction

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_fix(input string name, input fix_t got, input fix_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR time=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR time=%0t %s got=%b expected=%b", $time, name, got, exp);
        end
    endtask

    task automatic wait_idle();
        int n;
        for (n = 0; n < 64; n++) begin
            @(negedge clk);
            if (!busy) begin
                break;
            end
        end
        if (busy) begin
            timing_errors++;
            $display("busy did not drop within 64 cycles at time %0t", $time);
        end
    endtask

    // one item with its busy window, result edge and value
    task automatic eval_one(input fix_t x, input fix_t exp);
        int   n;
        logic seen;
        wait_idle();
        @(posedge clk);
        start <= 1'b1;
        x_in  <= x;
        @(posedge clk);  // accept edge
        start <= 1'b0;
        x_in  <= rand_fix();  // x must already be latched
        seen = 1'b0;
        for (n = 0; n <= Y_EDGE + 8; n++) begin
            @(negedge clk);
            check_bit("busy", busy, n < BUSY_CYCLES);
            if (y_valid) begin
                seen = 1'b1;
                if (n != Y_EDGE) begin
                    timing_errors++;
                    $display("y_valid came %0d cycles after accept instead of %0d", n, Y_EDGE);
                end
                check_fix("y", y, exp);
                break;
            end
            @(posedge clk);
        end
        if (!seen) begin
            timing_errors++;
            $display("no y_valid within %0d cycles of accept for x=%h", Y_EDGE + 8, x);
        end else begin
            @(negedge clk);
            check_bit("y_valid", y_valid, 1'b0);  // single strobe
            check_fix("y", y, exp);               // holds
        end
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic test_reset();
        repeat (4) begin
            @(negedge clk);
            check_bit("busy", busy, 1'b0);
            check_bit("y_valid", y_valid, 1'b0);
            check_fix("y", y, 32'sh0000_0000);
        end
    endtask

    task automatic test_exact_values();
        eval_one(32'sh0000_0000, 32'sh0000_0000);
        eval_one(32'sh0001_0000, 32'sh0005_0000);  // 5.0
        eval_one(32'sh0000_8000, 32'sh0000_F800);  // 0.96875
        eval_one(32'sh0002_0000, 32'sh003E_0000);  // 62.0
        eval_one(32'shFFFF_0000, 32'shFFFF_0000);  // -1.0
    endtask

    task automatic test_negative_fraction();
        eval_one(32'shFFFF_4000, poly_ref(32'shFFFF_4000));  // -0.75
        eval_one(32'shFFFE_8000, poly_ref(32'shFFFE_8000));  // -1.5
        eval_one(32'sh0000_0001, 32'sh0000_0001);            // x2 underflows
        eval_one(32'shFFFF_FFFF, poly_ref(32'shFFFF_FFFF));
        eval_one(32'shFFFF_B333, poly_ref(32'shFFFF_B333));  // about -0.3
    endtask

    task automatic test_saturation();
        eval_one(32'sh00C8_0000, FIX_MAX);                   // +200.0 clamps every sum high
        eval_one(32'shFF38_0000, poly_ref(32'shFF38_0000));  // -200.0
    endtask

    task automatic test_random();
        fix_t x;
        repeat (30) begin
            x = rand_fix();
            eval_one(x, poly_ref(x));
        end
    endtask

    task automatic test_back_to_back();
        fix_t acc_x[$];
        int   acc_edge[$];
        int   n;
        int   last_acc;
        int   naccept;
        int   got;
        logic busy_exp;
        logic take;
        fix_t xv;
        int   e;
        wait_idle();
        n        = 0;
        last_acc = -1000;
        naccept  = 0;
        got      = 0;
        @(posedge clk);
        start <= 1'b1;
        x_in  <= rand_fix();
        while (got < 3 && n < 3 * (BUSY_CYCLES + 1) + Y_EDGE + 10) begin
            @(negedge clk);
            busy_exp = (n - last_acc) < BUSY_CYCLES;
            check_bit("busy", busy, busy_exp);
            if (y_valid) begin
                if (acc_edge.size() == 0) begin
                    timing_errors++;
                    $display("y_valid at time %0t with no item outstanding", $time);
                end else begin
                    e  = acc_edge.pop_front();
                    xv = acc_x.pop_front();
                    if (n - e != Y_EDGE) begin
                        timing_errors++;
                        $display("result came %0d cycles after its accept instead of %0d",
                                 n - e, Y_EDGE);
                    end
                    check_fix("y", y, poly_ref(xv));
                    got++;
                end
            end
            take = start && !busy_exp;
            xv   = x_in;
            @(posedge clk);
            n++;
            if (take) begin
                acc_x.push_back(xv);
                acc_edge.push_back(n);
                last_acc = n;
                naccept++;
            end
            if (naccept >= 3) begin
                start <= 1'b0;
            end
            x_in <= rand_fix();  // new value every cycle
        end
        if (got < 3) begin
            timing_errors++;
            $display("only %0d of 3 back-to-back results arrived", got);
        end
        // nothing else may come out
        repeat (2 * Y_EDGE) begin
            @(negedge clk);
            check_bit("y_valid", y_valid, 1'b0);
        end
        check_bit("busy", busy, 1'b0);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(32'h006a2fa6));
        rst_n <= 1'b0;
        start <= 1'b0;
        x_in  <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_exact_values();
        test_negative_fraction();
        test_saturation();
        test_random();
        test_back_to_back();

        $display("value errors: %0d, timing errors: %0d", value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
